// File: cu_control_top.sv
// one clock domain; rstn may be asynchronous, every stage runs on the internally synchronised reset
`timescale 1ns/1ps
`include "cu_defines.svh"

module cu_control_top import cu_pkg::*; (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic [`CU_CONFIG_WIDTH-1:0] cu_configure,
	input  logic                        wed_valid,
	input  logic [`CU_VERTEX_WIDTH-1:0] wed_num_vertices,
	input  logic                        rsp_valid,
	input  cu_unit_id_e                 rsp_cu_id,
	input  logic [`CU_COUNT_WIDTH-1:0]  rsp_count,
	input  logic                        vj_req_valid,
	input  logic [`CU_TAG_WIDTH-1:0]    vj_req_tag,
	input  logic                        ga_req_valid,
	input  logic [`CU_TAG_WIDTH-1:0]    ga_req_tag,
	input  logic                        rd_credit_return,
	output logic                        vj_req_ready,
	output logic                        ga_req_ready,
	output logic                        rd_cmd_valid,
	output logic [`CU_TAG_WIDTH-1:0]    rd_cmd_tag,
	output cu_requester_e               rd_cmd_source,
	output logic                        cu_done,
	output logic [`CU_VERTEX_WIDTH-1:0] cu_return_vertices,
	output logic [`CU_EDGE_WIDTH-1:0]   cu_return_edges,
	output logic [`CU_CONFIG_WIDTH-1:0] cu_status
);

	logic                        sys_rstn;
	logic [`CU_CONFIG_WIDTH-1:0] cfg_word;
	logic [`CU_VERTEX_WIDTH-1:0] num_vertices;
	logic                        cu_ready;
	logic                        lat_rsp_valid;
	cu_unit_id_e                 lat_rsp_cu_id;
	logic [`CU_COUNT_WIDTH-1:0]  lat_rsp_count;
	logic [`CU_VERTEX_WIDTH-1:0] vertex_total;
	logic [`CU_EDGE_WIDTH-1:0]   edge_total;

	//////////////////////////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////////////////////////

	cu_input_stage cu_input_stage_i (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.cu_configure     (cu_configure),
		.wed_valid        (wed_valid),
		.wed_num_vertices (wed_num_vertices),
		.rsp_valid        (rsp_valid),
		.rsp_cu_id        (rsp_cu_id),
		.rsp_count        (rsp_count),
		.sys_rstn         (sys_rstn),
		.cfg_word         (cfg_word),
		.num_vertices     (num_vertices),
		.cu_ready         (cu_ready),
		.lat_rsp_valid    (lat_rsp_valid),
		.lat_rsp_cu_id    (lat_rsp_cu_id),
		.lat_rsp_count    (lat_rsp_count)
	);

	cu_response_router cu_response_router_i (
		.clock         (clock),
		.sys_rstn      (sys_rstn),
		.cu_ready      (cu_ready),
		.lat_rsp_valid (lat_rsp_valid),
		.lat_rsp_cu_id (lat_rsp_cu_id),
		.lat_rsp_count (lat_rsp_count),
		.vertex_total  (vertex_total),
		.edge_total    (edge_total)
	);

	//////////////////////////////////////////////////////////////////////
	// read commands and completion
	//////////////////////////////////////////////////////////////////////

	cu_read_arbiter cu_read_arbiter_i (
		.clock            (clock),
		.sys_rstn         (sys_rstn),
		.cu_ready         (cu_ready),
		.vj_req_valid     (vj_req_valid),
		.vj_req_tag       (vj_req_tag),
		.ga_req_valid     (ga_req_valid),
		.ga_req_tag       (ga_req_tag),
		.rd_credit_return (rd_credit_return),
		.vj_req_ready     (vj_req_ready),
		.ga_req_ready     (ga_req_ready),
		.rd_cmd_valid     (rd_cmd_valid),
		.rd_cmd_tag       (rd_cmd_tag),
		.rd_cmd_source    (rd_cmd_source)
	);

	cu_done_control cu_done_control_i (
		.clock              (clock),
		.sys_rstn           (sys_rstn),
		.cu_ready           (cu_ready),
		.cfg_word           (cfg_word),
		.num_vertices       (num_vertices),
		.vertex_total       (vertex_total),
		.edge_total         (edge_total),
		.cu_done            (cu_done),
		.cu_return_vertices (cu_return_vertices),
		.cu_return_edges    (cu_return_edges),
		.cu_status          (cu_status)
	);

endmodule

// File: cu_defines.svh
// single clock domain assumed; values are not range checked, keep CU_READ_CREDITS at 1 or more
`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// vertex totals and the descriptor vertex count
`define CU_VERTEX_WIDTH 32
`define CU_EDGE_WIDTH 32
// count carried by a single read response
`define CU_COUNT_WIDTH 8
// configuration word and status
`define CU_CONFIG_WIDTH 32
`define CU_ID_WIDTH 4
`define CU_TAG_WIDTH 16

//////////////////////////////////////////////////////////////////////
// read command flow control
//////////////////////////////////////////////////////////////////////

// credits held by the arbiter right after reset
`define CU_READ_CREDITS 4

`endif

// File: cu_done_control.sv
// done needs an exact match with a nonzero vertex count; an overshoot never completes the job
`timescale 1ns/1ps
`include "cu_defines.svh"

module cu_done_control import cu_pkg::*; (
	input  logic                        clock,
	input  logic                        sys_rstn,
	input  logic                        cu_ready,
	input  logic [`CU_CONFIG_WIDTH-1:0] cfg_word,
	input  logic [`CU_VERTEX_WIDTH-1:0] num_vertices,
	input  logic [`CU_VERTEX_WIDTH-1:0] vertex_total,
	input  logic [`CU_EDGE_WIDTH-1:0]   edge_total,
	output logic                        cu_done,
	output logic [`CU_VERTEX_WIDTH-1:0] cu_return_vertices,
	output logic [`CU_EDGE_WIDTH-1:0]   cu_return_edges,
	output logic [`CU_CONFIG_WIDTH-1:0] cu_status
);

	cu_job_state_e job_state;
	cu_job_state_e job_state_next;
	logic          all_vertices;

	//////////////////////////////////////////////////////////////////////
	// job FSM
	//////////////////////////////////////////////////////////////////////

	assign all_vertices = (num_vertices != '0) && (vertex_total == num_vertices);

	always_comb begin
		job_state_next = job_state;
		case (job_state)
			JOB_IDLE: begin
				if (cu_ready) begin
					job_state_next = JOB_RUNNING;
				end
			end
			JOB_RUNNING: begin
				if (all_vertices) begin
					job_state_next = JOB_DONE;
				end
			end
			// done holds until the next reset
			JOB_DONE: job_state_next = JOB_DONE;
			default: job_state_next = JOB_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge sys_rstn) begin
		if (!sys_rstn) begin
			job_state <= JOB_IDLE;
		end else begin
			job_state <= job_state_next;
		end
	end

	assign cu_done = (job_state == JOB_DONE);

	//////////////////////////////////////////////////////////////////////
	// return values and status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge sys_rstn) begin
		if (!sys_rstn) begin
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
			cu_status          <= '0;
		end else begin
			cu_return_vertices <= vertex_total;
			cu_return_edges    <= edge_total;
			cu_status          <= cfg_word;
		end
	end

endmodule

// File: cu_input_stage.sv
// inputs are sampled one cycle behind the registered enable; the descriptor stays latched until reset
`timescale 1ns/1ps
`include "cu_defines.svh"

module cu_input_stage import cu_pkg::*; (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic [`CU_CONFIG_WIDTH-1:0] cu_configure,
	input  logic                        wed_valid,
	input  logic [`CU_VERTEX_WIDTH-1:0] wed_num_vertices,
	input  logic                        rsp_valid,
	input  cu_unit_id_e                 rsp_cu_id,
	input  logic [`CU_COUNT_WIDTH-1:0]  rsp_count,
	output logic                        sys_rstn,
	output logic [`CU_CONFIG_WIDTH-1:0] cfg_word,
	output logic [`CU_VERTEX_WIDTH-1:0] num_vertices,
	output logic                        cu_ready,
	output logic                        lat_rsp_valid,
	output cu_unit_id_e                 lat_rsp_cu_id,
	output logic [`CU_COUNT_WIDTH-1:0]  lat_rsp_count
);

	logic rstn_meta;
	logic enabled_q;
	logic wed_valid_q;

	//////////////////////////////////////////////////////////////////////
	// reset synchroniser
	//////////////////////////////////////////////////////////////////////

	// assert at once, release two clocks after rstn rises
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rstn_meta <= 1'b0;
			sys_rstn  <= 1'b0;
		end else begin
			rstn_meta <= 1'b1;
			sys_rstn  <= rstn_meta;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// enable, descriptor and configuration
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge sys_rstn) begin
		if (!sys_rstn) begin
			enabled_q    <= 1'b0;
			wed_valid_q  <= 1'b0;
			num_vertices <= '0;
			cfg_word     <= '0;
		end else begin
			enabled_q <= enabled;
			if (enabled_q) begin
				// first valid descriptor sticks for the rest of the job
				if (wed_valid) begin
					wed_valid_q  <= 1'b1;
					num_vertices <= wed_num_vertices;
				end
				// a zero write means no new configuration
				if (|cu_configure) begin
					cfg_word <= cu_configure;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read response capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge sys_rstn) begin
		if (!sys_rstn) begin
			lat_rsp_valid <= 1'b0;
		end else begin
			lat_rsp_valid <= enabled_q && rsp_valid;
		end
	end

	// payload only matters when lat_rsp_valid is set
	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			lat_rsp_cu_id <= rsp_cu_id;
			lat_rsp_count <= rsp_count;
		end
	end

	assign cu_ready = (|cfg_word) && wed_valid_q;

endmodule

// File: cu_pkg.sv
// enum widths follow cu_defines.svh; unit ids above CU_GRAPH_ALGO_1 are legal and count as edges
`include "cu_defines.svh"

package cu_pkg;

	//////////////////////////////////////////////////////////////////////
	// unit ids carried by read responses
	//////////////////////////////////////////////////////////////////////

	// only the vertex control id is decoded, any other id is an edge response
	typedef enum logic [`CU_ID_WIDTH-1:0] {
		CU_VERTEX_CONTROL = 'd0,
		CU_GRAPH_ALGO_0   = 'd1,
		CU_GRAPH_ALGO_1   = 'd2
	} cu_unit_id_e;

	// read requesters, also the source field of an issued command
	typedef enum logic {
		REQ_VERTEX_JOB = 1'b0,
		REQ_GRAPH_ALGO = 1'b1
	} cu_requester_e;

	//////////////////////////////////////////////////////////////////////
	// job progress
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		JOB_IDLE    = 2'd0,
		JOB_RUNNING = 2'd1,
		JOB_DONE    = 2'd2
	} cu_job_state_e;

endpackage

// File: cu_read_arbiter.sv
// memory has no ready; flow control is only the credit count, and extra returns beyond the max are dropped
`timescale 1ns/1ps
`include "cu_defines.svh"

module cu_read_arbiter import cu_pkg::*; (
	input  logic                     clock,
	input  logic                     sys_rstn,
	input  logic                     cu_ready,
	input  logic                     vj_req_valid,
	input  logic [`CU_TAG_WIDTH-1:0] vj_req_tag,
	input  logic                     ga_req_valid,
	input  logic [`CU_TAG_WIDTH-1:0] ga_req_tag,
	input  logic                     rd_credit_return,
	output logic                     vj_req_ready,
	output logic                     ga_req_ready,
	output logic                     rd_cmd_valid,
	output logic [`CU_TAG_WIDTH-1:0] rd_cmd_tag,
	output cu_requester_e            rd_cmd_source
);

	localparam int CREDIT_W = $clog2(`CU_READ_CREDITS + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`CU_READ_CREDITS);

	logic [CREDIT_W-1:0] credits;
	cu_requester_e       last_grant;
	logic                can_issue;
	logic                both_req;
	logic                pick_vj;
	logic                pick_ga;
	logic                accept;

	//////////////////////////////////////////////////////////////////////
	// round robin grant
	//////////////////////////////////////////////////////////////////////

	assign can_issue = cu_ready && (credits != '0);
	assign both_req  = vj_req_valid && ga_req_valid;

	// on a tie the requester that lost last time wins
	assign pick_vj = can_issue && vj_req_valid &&
		(!both_req || (last_grant == REQ_GRAPH_ALGO));
	assign pick_ga = can_issue && ga_req_valid &&
		(!both_req || (last_grant == REQ_VERTEX_JOB));
	assign accept  = pick_vj || pick_ga;

	assign vj_req_ready = pick_vj;
	assign ga_req_ready = pick_ga;

	//////////////////////////////////////////////////////////////////////
	// credit counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge sys_rstn) begin
		if (!sys_rstn) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({accept, rd_credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: begin
					if (credits != CREDIT_MAX) begin
						credits <= credits + 1'b1;
					end
				end
				// spent and returned in one cycle cancel out
				default: credits <= credits;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command register
	//////////////////////////////////////////////////////////////////////

	// vertex job goes first after reset
	always_ff @(posedge clock or negedge sys_rstn) begin
		if (!sys_rstn) begin
			rd_cmd_valid <= 1'b0;
			last_grant   <= REQ_GRAPH_ALGO;
		end else begin
			rd_cmd_valid <= accept;
			if (accept) begin
				last_grant <= pick_vj ? REQ_VERTEX_JOB : REQ_GRAPH_ALGO;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rd_cmd_tag <= pick_vj ? vj_req_tag : ga_req_tag;
		end
	end

	// the last winner is the source of the command now on the bus
	assign rd_cmd_source = last_grant;

endmodule

// File: cu_response_router.sv
// totals wrap silently on overflow; responses arriving before cu_ready are dropped
`timescale 1ns/1ps
`include "cu_defines.svh"

module cu_response_router import cu_pkg::*; (
	input  logic                        clock,
	input  logic                        sys_rstn,
	input  logic                        cu_ready,
	input  logic                        lat_rsp_valid,
	input  cu_unit_id_e                 lat_rsp_cu_id,
	input  logic [`CU_COUNT_WIDTH-1:0]  lat_rsp_count,
	output logic [`CU_VERTEX_WIDTH-1:0] vertex_total,
	output logic [`CU_EDGE_WIDTH-1:0]   edge_total
);

	logic                        rsp_take;
	logic                        is_vertex;
	logic [`CU_VERTEX_WIDTH-1:0] vertex_add;
	logic [`CU_EDGE_WIDTH-1:0]   edge_add;

	//////////////////////////////////////////////////////////////////////
	// id decode
	//////////////////////////////////////////////////////////////////////

	assign rsp_take  = cu_ready && lat_rsp_valid;
	assign is_vertex = (lat_rsp_cu_id == CU_VERTEX_CONTROL);

	// zero extend the response count to each total
	assign vertex_add = {{(`CU_VERTEX_WIDTH - `CU_COUNT_WIDTH){1'b0}}, lat_rsp_count};
	assign edge_add   = {{(`CU_EDGE_WIDTH - `CU_COUNT_WIDTH){1'b0}}, lat_rsp_count};

	//////////////////////////////////////////////////////////////////////
	// running totals
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge sys_rstn) begin
		if (!sys_rstn) begin
			vertex_total <= '0;
			edge_total   <= '0;
		end else if (rsp_take) begin
			if (is_vertex) begin
				vertex_total <= vertex_total + vertex_add;
			end else begin
				// every graph algorithm unit, known id or not
				edge_total <= edge_total + edge_add;
			end
		end
	end

endmodule

// File: tb_cu_control.sv
// one directed sequence with seeded random responses; the first failing check ends the run
`timescale 1ns/1ps
`include "cu_defines.svh"

module tb_cu_control import cu_pkg::*; ();

	localparam int N_RSP      = 48;
	localparam int N_IDLE_RSP = 6;
	localparam int N_RETURNS  = 3;
	localparam int N_TRANS    = N_RSP + N_IDLE_RSP + `CU_READ_CREDITS + N_RETURNS + 2;
	localparam int LIMIT      = 40 * N_TRANS + 200;

	logic                        clock;
	logic                        rstn;
	logic                        enabled;
	logic [`CU_CONFIG_WIDTH-1:0] cu_configure;
	logic                        wed_valid;
	logic [`CU_VERTEX_WIDTH-1:0] wed_num_vertices;
	logic                        rsp_valid;
	cu_unit_id_e                 rsp_cu_id;
	logic [`CU_COUNT_WIDTH-1:0]  rsp_count;
	logic                        vj_req_valid;
	logic [`CU_TAG_WIDTH-1:0]    vj_req_tag;
	logic                        ga_req_valid;
	logic [`CU_TAG_WIDTH-1:0]    ga_req_tag;
	logic                        rd_credit_return;
	logic                        vj_req_ready;
	logic                        ga_req_ready;
	logic                        rd_cmd_valid;
	logic [`CU_TAG_WIDTH-1:0]    rd_cmd_tag;
	cu_requester_e               rd_cmd_source;
	logic                        cu_done;
	logic [`CU_VERTEX_WIDTH-1:0] cu_return_vertices;
	logic [`CU_EDGE_WIDTH-1:0]   cu_return_edges;
	logic [`CU_CONFIG_WIDTH-1:0] cu_status;

	// model state with totals packed as {vertex, edge}
	logic [63:0]                 exp_totals;
	logic [`CU_VERTEX_WIDTH-1:0] exp_num;
	logic [`CU_CONFIG_WIDTH-1:0] exp_status;
	cu_requester_e               model_last;
	cu_requester_e               exp_src_q[$];
	logic [`CU_TAG_WIDTH-1:0]    exp_tag_q[$];
	cu_requester_e               cmd_src;
	logic [1:0]                  ready_prev;
	logic [31:0]                 rng_state;
	cu_unit_id_e                 rsp_ids[N_RSP];
	logic [`CU_COUNT_WIDTH-1:0]  rsp_counts[N_RSP];
	int                          cmd_count;
	int                          error_count;
	bit                          checking;
	bit                          done_seen;

	cu_control_top cu_control_top_i (.*);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// vertex control responses add to the vertex total and any other id to edges
	function automatic logic [63:0] model_route(input logic [63:0] totals,
		input cu_unit_id_e id, input logic [`CU_COUNT_WIDTH-1:0] count);
		if (id == CU_VERTEX_CONTROL) begin
			return {totals[63:32] + 32'(count), totals[31:0]};
		end
		return {totals[63:32], totals[31:0] + 32'(count)};
	endfunction

	// with both requesters held the grant flips every issue
	function automatic cu_requester_e next_source(input cu_requester_e last);
		return (last == REQ_VERTEX_JOB) ? REQ_GRAPH_ALGO : REQ_VERTEX_JOB;
	endfunction

	task automatic expect_command();
		model_last = next_source(model_last);
		exp_src_q.push_back(model_last);
		exp_tag_q.push_back((model_last == REQ_VERTEX_JOB) ? vj_req_tag : ga_req_tag);
	endtask

	//////////////////////////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_error();
		error_count++;
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
			stop_with_error();
		end
	endtask

	// every issued command must be the next one the model predicts
	// and the ready of its source must have been the only one high a cycle before
	always @(negedge clock) begin
		if (checking) begin
			if (rd_cmd_valid !== 1'b1) begin
				check_value("vj_req_ready", 0, ready_prev[1]);
				check_value("ga_req_ready", 0, ready_prev[0]);
			end else if (exp_src_q.size() == 0) begin
				$display("a read command was issued at %0t when none was expected", $time);
				stop_with_error();
			end else begin
				cmd_src = exp_src_q.pop_front();
				check_value("vj_req_ready", cmd_src == REQ_VERTEX_JOB, ready_prev[1]);
				check_value("ga_req_ready", cmd_src == REQ_GRAPH_ALGO, ready_prev[0]);
				check_value("rd_cmd_source", cmd_src, rd_cmd_source);
				check_value("rd_cmd_tag", exp_tag_q.pop_front(), rd_cmd_tag);
				cmd_count++;
			end
		end
		ready_prev = {vj_req_ready, ga_req_ready};
	end

	// done may only rise at the vertex count and then has to stay
	always @(negedge clock) begin
		if (checking) begin
			if (done_seen && cu_done !== 1'b1) begin
				$display("cu_done fell at %0t after it had been set", $time);
				stop_with_error();
			end else if (!done_seen && cu_done === 1'b1) begin
				check_value("cu_done", (exp_num != 0) && (exp_totals[63:32] == exp_num), cu_done);
				done_seen = 1'b1;
			end
		end
	end

	initial begin
		repeat (LIMIT) @(posedge clock);
		$display("timeout: the run did not end within %0d cycles", LIMIT);
		stop_with_error();
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// inputs change half a nanosecond after the rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
		#0.5;
	endtask

	task automatic send_response(input cu_unit_id_e id, input logic [`CU_COUNT_WIDTH-1:0] count,
		input bit counted);
		rsp_valid = 1'b1;
		rsp_cu_id = id;
		rsp_count = count;
		if (counted) begin
			exp_totals = model_route(exp_totals, id, count);
		end
		wait_cycles(1);
		rsp_valid = 1'b0;
	endtask

	task automatic check_idle_outputs();
		check_value("vj_req_ready", 0, vj_req_ready);
		check_value("ga_req_ready", 0, ga_req_ready);
	endtask

	initial begin
		int i;
		logic [31:0] vertex_sum;
		clock = 1'b0;
		rstn = 1'b0;
		enabled = 1'b0;
		cu_configure = '0;
		wed_valid = 1'b0;
		wed_num_vertices = '0;
		rsp_valid = 1'b0;
		rsp_cu_id = CU_VERTEX_CONTROL;
		rsp_count = '0;
		vj_req_valid = 1'b0;
		vj_req_tag = '0;
		ga_req_valid = 1'b0;
		ga_req_tag = '0;
		rd_credit_return = 1'b0;
		exp_totals = '0;
		exp_num = '0;
		model_last = REQ_GRAPH_ALGO;
		rng_state = 32'hd347;
		wait_cycles(2);
		rstn = 1'b1;
		wait_cycles(4);
		checking = 1'b1;
		@(negedge clock);
		check_value("cu_done", 0, cu_done);
		check_value("rd_cmd_valid", 0, rd_cmd_valid);
		check_idle_outputs();
		check_value("cu_return_vertices", 0, cu_return_vertices);
		check_value("cu_return_edges", 0, cu_return_edges);

		// configuration alone must not let the held requesters through
		wait_cycles(1);
		rng_state = xorshift32(rng_state);
		vj_req_valid = 1'b1;
		vj_req_tag = rng_state[15:0];
		ga_req_valid = 1'b1;
		ga_req_tag = rng_state[31:16];
		enabled = 1'b1;
		wait_cycles(1);
		rng_state = xorshift32(rng_state);
		exp_status = rng_state | 32'h1;
		cu_configure = exp_status;
		wait_cycles(1);
		cu_configure = '0;
		wait_cycles(4);
		@(negedge clock);
		check_value("cu_status", exp_status, cu_status);
		check_idle_outputs();
		wait_cycles(1);
		vj_req_valid = 1'b0;
		ga_req_valid = 1'b0;

		// the descriptor count is the vertex sum of the whole stream
		vertex_sum = '0;
		for (i = 0; i < N_RSP; i++) begin
			rng_state = xorshift32(rng_state);
			rsp_ids[i] = cu_unit_id_e'(`CU_ID_WIDTH'(rng_state[1:0]));
			rsp_counts[i] = rng_state[15:8];
			if (i == 0) begin
				rsp_ids[i] = CU_VERTEX_CONTROL;
				rsp_counts[i] = rng_state[15:8] | 8'h01;
			end
			if (rsp_ids[i] == CU_VERTEX_CONTROL) begin
				vertex_sum = vertex_sum + rsp_counts[i];
			end
		end
		exp_num = vertex_sum;
		wed_valid = 1'b1;
		wed_num_vertices = vertex_sum;
		wait_cycles(1);
		wed_valid = 1'b0;
		wait_cycles(2);
		for (i = 0; i < N_RSP; i++) begin
			send_response(rsp_ids[i], rsp_counts[i], 1'b1);
			rng_state = xorshift32(rng_state);
			if (rng_state[2:0] == 3'd0) begin
				wait_cycles(1);
			end
		end
		for (i = 0; i < 20 && cu_done !== 1'b1; i++) begin
			@(negedge clock);
		end
		if (cu_done !== 1'b1) begin
			$display("cu_done did not rise once the vertex count was reached");
			stop_with_error();
		end
		wait_cycles(4);
		@(negedge clock);
		check_value("cu_return_vertices", exp_totals[63:32], cu_return_vertices);
		check_value("cu_return_edges", exp_totals[31:0], cu_return_edges);

		// with both requesters held the credit pool sets how many commands go out
		wait_cycles(1);
		repeat (`CU_READ_CREDITS) expect_command();
		vj_req_valid = 1'b1;
		ga_req_valid = 1'b1;
		wait_cycles(2 * `CU_READ_CREDITS + 4);
		@(negedge clock);
		check_value("commands issued", `CU_READ_CREDITS, cmd_count);
		check_idle_outputs();
		for (i = 0; i < N_RETURNS; i++) begin
			wait_cycles(1);
			expect_command();
			rd_credit_return = 1'b1;
			wait_cycles(1);
			rd_credit_return = 1'b0;
			wait_cycles(4);
			@(negedge clock);
			check_value("commands issued", `CU_READ_CREDITS + i + 1, cmd_count);
			check_idle_outputs();
		end
		wait_cycles(1);
		vj_req_valid = 1'b0;
		ga_req_valid = 1'b0;

		// disabled block ignores responses and configuration
		enabled = 1'b0;
		wait_cycles(2);
		cu_configure = exp_status ^ 32'hffff_0000;
		for (i = 0; i < N_IDLE_RSP; i++) begin
			rng_state = xorshift32(rng_state);
			send_response(cu_unit_id_e'(`CU_ID_WIDTH'(rng_state[1:0])),
				rng_state[15:8] | 8'h01, 1'b0);
		end
		cu_configure = '0;
		wait_cycles(4);
		@(negedge clock);
		check_value("cu_return_vertices", exp_totals[63:32], cu_return_vertices);
		check_value("cu_return_edges", exp_totals[31:0], cu_return_edges);
		check_value("cu_status", exp_status, cu_status);
		check_value("cu_done", 1, cu_done);
		check_value("pending commands", 0, exp_src_q.size());

		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
cu_pkg.sv
cu_input_stage.sv
cu_response_router.sv
cu_read_arbiter.sv
cu_done_control.sv
cu_control_top.sv
tb_cu_control.sv
